/* Makefile */
TOP := cpu_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): cpu.f $(wildcard hw/*.sv verif/*.sv)
	verilator --binary --timing --assert -f cpu.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

lint:
	verilator --lint-only -Wall --timing -f cpu.f --top-module cpu

clean:
	rm -rf obj_dir

/* cpu.f */
hw/rv_pkg.sv
hw/instr_decode.sv
hw/alu.sv
hw/reg_bank.sv
hw/datapath.sv
hw/cpu.sv
verif/cpu_tb.sv

/* hw/alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_pkg::xlen_t   a,
    input  rv_pkg::xlen_t   b,
    input  rv_pkg::alu_op_t alu_op,
    output rv_pkg::xlen_t   y
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (alu_op)
            rv_pkg::ALU_ADD: begin
                y = a + b;
            end
            rv_pkg::ALU_SUB: begin
                y = a - b;
            end
            rv_pkg::ALU_SLL: begin
                y = a << shamt;
            end
            rv_pkg::ALU_SLT: begin
                y = {31'b0, lt_signed};
            end
            rv_pkg::ALU_SLTU: begin
                y = {31'b0, lt_unsigned};
            end
            rv_pkg::ALU_XOR: begin
                y = a ^ b;
            end
            rv_pkg::ALU_SRL: begin
                y = a >> shamt;
            end
            rv_pkg::ALU_SRA: begin
                y = rv_pkg::xlen_t'($signed(a) >>> shamt);  // Sign fill
            end
            rv_pkg::ALU_OR: begin
                y = a | b;
            end
            rv_pkg::ALU_AND: begin
                y = a & b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule : alu

/* hw/cpu.sv */
`timescale 1ns/1ps

module cpu (
    input  logic                      clk,
    input  logic                      rst_n,
    input  rv_pkg::instr_t            instruction,
    output rv_pkg::addr_t             pc_out,
    output logic [rv_pkg::LED_W-1:0]  led
);

    rv_pkg::ctrl_state_t state;

    rv_pkg::reg_idx_t rs1;
    rv_pkg::reg_idx_t rs2;
    rv_pkg::reg_idx_t rd;
    rv_pkg::xlen_t    imm;
    rv_pkg::alu_op_t  alu_op;
    logic             use_imm;
    logic             supported;

    logic             use_imm_q;   // Operand select held for write back
    logic             reg_write;
    logic             pc_en;
    rv_pkg::addr_t    pc_next;
    rv_pkg::xlen_t    result;

    instr_decode decode_i (
        .instruction (instruction),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .supported   (supported)
    );

    datapath datapath_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .imm       (imm),
        .alu_op    (alu_op),
        .use_imm   (use_imm_q),
        .reg_write (reg_write),
        .result    (result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= rv_pkg::START;
            reg_write <= 1'b0;
            use_imm_q <= 1'b0;
        end else begin
            case (state)
                rv_pkg::START: begin
                    if (supported) begin
                        state <= rv_pkg::OPERATE_ALU;  // Unknown opcodes park here
                    end
                end
                rv_pkg::OPERATE_ALU: begin
                    state     <= rv_pkg::WRITE_BACK;
                    reg_write <= 1'b1;
                    use_imm_q <= use_imm;
                end
                rv_pkg::WRITE_BACK: begin
                    state     <= rv_pkg::INCREMENT_PC;
                    reg_write <= 1'b0;
                end
                rv_pkg::INCREMENT_PC: begin
                    state <= rv_pkg::COMPLETE;
                end
                default: begin
                    state <= rv_pkg::START;  // COMPLETE
                end
            endcase
        end
    end

    // Program counter
    assign pc_en   = (state == rv_pkg::INCREMENT_PC);
    assign pc_next = pc_out + rv_pkg::PC_STEP;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_out <= '0;
        end else if (pc_en) begin
            pc_out <= pc_next;
        end
    end

    // LED shows the byte written back
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led <= '0;
        end else if (reg_write) begin
            led <= result[rv_pkg::LED_W-1:0];
        end
    end

    a_write_only_in_wb: assert property (
        @(posedge clk) disable iff (!rst_n)
        reg_write |-> (state == rv_pkg::WRITE_BACK)
    ) else $error("reg_write high outside WRITE_BACK");

    a_pc_step: assert property (
        @(posedge clk) disable iff (!rst_n)
        $changed(pc_out) |-> (pc_out == $past(pc_out) + rv_pkg::PC_STEP)
    ) else $error("pc_out moved by other than PC_STEP");

    a_back_to_start: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == rv_pkg::START) ##1 (state != rv_pkg::START)
            |-> ##[1:4] (state == rv_pkg::START)
    ) else $error("control did not return to START");

endmodule : cpu

/* hw/datapath.sv */
`timescale 1ns/1ps

module datapath (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::xlen_t    imm,
    input  rv_pkg::alu_op_t  alu_op,
    input  logic             use_imm,
    input  logic             reg_write,
    output rv_pkg::xlen_t    result
);

    rv_pkg::xlen_t read_data1;
    rv_pkg::xlen_t read_data2;
    rv_pkg::xlen_t alu_b;

    reg_bank reg_bank_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .write_en   (reg_write),
        .write_data (result),      // ALU result goes straight back
        .read_data1 (read_data1),
        .read_data2 (read_data2)
    );

    // Second operand from rs2 or the immediate
    assign alu_b = use_imm ? imm : read_data2;

    alu alu_i (
        .a      (read_data1),
        .b      (alu_b),
        .alu_op (alu_op),
        .y      (result)
    );

endmodule : datapath

/* hw/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
    input  rv_pkg::instr_t   instruction,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd,
    output rv_pkg::xlen_t    imm,
    output rv_pkg::alu_op_t  alu_op,
    output logic             use_imm,
    output logic             supported
);

    rv_pkg::opcode_t opcode;
    rv_pkg::funct3_t funct3;
    logic            alt;        // funct7 bit 5
    logic            is_r_type;
    logic            is_i_type;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    assign alt    = instruction[30];

    assign rs1 = instruction[19:15];
    assign rs2 = instruction[24:20];
    assign rd  = instruction[11:7];

    // I immediate, low five bits double as shamt
    assign imm = {{20{instruction[31]}}, instruction[31:20]};

    assign is_r_type = (opcode == rv_pkg::OPCODE_R_TYPE);
    assign is_i_type = (opcode == rv_pkg::OPCODE_I_TYPE);

    assign use_imm   = is_i_type;
    assign supported = is_r_type | is_i_type;

    always_comb begin
        case (funct3)
            rv_pkg::F3_ADD_SUB: begin
                // No SUBI, so bit 30 only matters on R-type
                if (is_r_type && alt) begin
                    alu_op = rv_pkg::ALU_SUB;
                end else begin
                    alu_op = rv_pkg::ALU_ADD;
                end
            end
            rv_pkg::F3_SLL: begin
                alu_op = rv_pkg::ALU_SLL;
            end
            rv_pkg::F3_SLT: begin
                alu_op = rv_pkg::ALU_SLT;
            end
            rv_pkg::F3_SLTU: begin
                alu_op = rv_pkg::ALU_SLTU;
            end
            rv_pkg::F3_XOR: begin
                alu_op = rv_pkg::ALU_XOR;
            end
            rv_pkg::F3_SRL_SRA: begin
                if (alt) begin
                    alu_op = rv_pkg::ALU_SRA;  // SRA and SRAI
                end else begin
                    alu_op = rv_pkg::ALU_SRL;
                end
            end
            rv_pkg::F3_OR: begin
                alu_op = rv_pkg::ALU_OR;
            end
            default: begin
                alu_op = rv_pkg::ALU_AND;  // funct3 111
            end
        endcase
    end

endmodule : instr_decode

/* hw/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank (
    input  logic             clk,
    input  logic             rst_n,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             write_en,
    input  rv_pkg::xlen_t    write_data,
    output rv_pkg::xlen_t    read_data1,
    output rv_pkg::xlen_t    read_data2
);

    rv_pkg::xlen_t regs [rv_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < rv_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && (rd != '0)) begin
            regs[rd] <= write_data;  // x0 stays zero
        end
    end

    assign read_data1 = (rs1 == '0) ? '0 : regs[rs1];
    assign read_data2 = (rs2 == '0) ? '0 : regs[rs2];

    // Control from the FSM must be clean once out of reset
    a_write_en_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(write_en)
    ) else $error("reg_bank write_en is unknown");

endmodule : reg_bank

/* hw/rv_pkg.sv */
package rv_pkg;

    // Data and address widths
    typedef logic [31:0] xlen_t;
    typedef logic [31:0] addr_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    localparam int NUM_REGS = 32;
    localparam int LED_W    = 8;

    localparam addr_t PC_STEP = 32'd4;  // One word per instruction

    // Supported major opcodes
    localparam opcode_t OPCODE_R_TYPE = 7'b0110011;
    localparam opcode_t OPCODE_I_TYPE = 7'b0010011;

    // funct3 encodings shared by OP and OP-IMM
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_t;

    // Five cycles per instruction
    typedef enum logic [2:0] {
        START        = 3'd0,
        OPERATE_ALU  = 3'd1,
        WRITE_BACK   = 3'd2,
        INCREMENT_PC = 3'd3,
        COMPLETE     = 3'd4
    } ctrl_state_t;

endpackage : rv_pkg

/* verif/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;

    localparam int ROM_DEPTH    = 64;
    localparam int NUM_SEEDS    = 8;
    localparam int X0_READ_IDX  = 9;   // ADD x9, x0, x0
    localparam int NUM_RANDOM   = 40;
    localparam int BAD_IDX      = 30;  // Unsupported word sits here
    localparam int NUM_RETIRE   = 50;
    localparam int STALL_CYCLES = 20;
    localparam int CYCLE_LIMIT  = 400;
    localparam logic [31:0] BAD_WORD = 32'h0040_006f;  // JAL

    logic           clk;
    logic           rst_n;
    rv_pkg::instr_t instruction;
    rv_pkg::addr_t  pc_out;
    logic [7:0]     led;

    logic [31:0]   rom [ROM_DEPTH];
    rv_pkg::xlen_t shadow [32];
    logic [31:0]   lfsr_state;

    int            phase;      // 0 START .. 4 COMPLETE
    int            skip;
    int            stall_cycles;
    int            retired;
    int            cycle_count;
    int            exec_idx;
    logic [31:0]   exp_pc;
    rv_pkg::xlen_t exp_result;
    logic [7:0]    exp_led;
    logic [4:0]    exp_rd;
    logic          x0_probe;
    logic          x0_checked;
    logic [31:0]   pc_prev;
    logic [7:0]    led_prev;
    logic          stall_active;

    cpu dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instruction (instruction),
        .pc_out      (pc_out),
        .led         (led)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run;
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        abort_run();
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'hd000_0001) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    // k: 0..9 R-type ADD..AND, 10..18 ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI
    function automatic logic [31:0] encode_op(input int k, input logic [4:0] rd,
                                              input logic [4:0] rs1, input logic [4:0] rs2,
                                              input logic [11:0] imm);
        logic [2:0]  f3;
        logic [11:0] imm_field;
        case (k)
            0, 1, 10:  f3 = 3'b000;
            2, 16:     f3 = 3'b001;
            3, 11:     f3 = 3'b010;
            4, 12:     f3 = 3'b011;
            5, 13:     f3 = 3'b100;
            6, 7, 17, 18: f3 = 3'b101;
            8, 14:     f3 = 3'b110;
            default:   f3 = 3'b111;
        endcase
        if (k < 10) begin
            encode_op = {((k == 1) || (k == 7)) ? 7'b0100000 : 7'b0000000,
                         rs2, rs1, f3, rd, rv_pkg::OPCODE_R_TYPE};
        end else begin
            imm_field = (k >= 16) ? {(k == 18) ? 7'b0100000 : 7'b0000000, imm[4:0]} : imm;
            encode_op = {imm_field, rs1, f3, rd, rv_pkg::OPCODE_I_TYPE};
        end
    endfunction

    function automatic logic is_supported(input logic [31:0] ins);
        is_supported = (ins[6:0] == rv_pkg::OPCODE_R_TYPE) ||
                       (ins[6:0] == rv_pkg::OPCODE_I_TYPE);
    endfunction

    // ISA semantics of OP and OP-IMM
    function automatic logic [31:0] ref_result(input logic [31:0] ins, input logic [31:0] a,
                                               input logic [31:0] r2);
        logic        is_imm;
        logic [31:0] b;
        logic [4:0]  sh;
        is_imm = (ins[6:0] == rv_pkg::OPCODE_I_TYPE);
        b      = is_imm ? {{20{ins[31]}}, ins[31:20]} : r2;
        sh     = b[4:0];
        case (ins[14:12])
            3'b000:  ref_result = (!is_imm && ins[30]) ? a - b : a + b;
            3'b001:  ref_result = a << sh;
            3'b010:  ref_result = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'b011:  ref_result = {31'b0, a < b};
            3'b100:  ref_result = a ^ b;
            3'b101:  ref_result = ins[30] ? ((a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}}))
                                          : (a >> sh);
            3'b110:  ref_result = a | b;
            default: ref_result = a & b;
        endcase
    endfunction

    function automatic logic [31:0] rom_word(input int idx);
        rom_word = (idx < ROM_DEPTH) ? rom[idx] : 32'h0;
    endfunction

    task automatic build_program;
        logic [31:0] start;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        int          slot;
        int          op;
        for (int i = 0; i < ROM_DEPTH; i++) begin
            rom[i] = 32'h0;
        end
        rom[0] = encode_op(10, 5'd1, 5'd0, 5'd0, 12'hffb);  // Negative seeds mixed in
        rom[1] = encode_op(10, 5'd2, 5'd0, 5'd0, 12'h7ff);
        rom[2] = encode_op(10, 5'd3, 5'd0, 5'd0, 12'h800);
        rom[3] = encode_op(10, 5'd4, 5'd0, 5'd0, 12'h001);
        rom[4] = encode_op(10, 5'd5, 5'd0, 5'd0, 12'hfff);
        rom[5] = encode_op(10, 5'd6, 5'd0, 5'd0, 12'h123);
        rom[6] = encode_op(10, 5'd7, 5'd0, 5'd0, 12'hf00);
        rom[7] = encode_op(10, 5'd8, 5'd0, 5'd0, 12'h055);
        rom[NUM_SEEDS] = encode_op(10, 5'd0, 5'd0, 5'd0, 12'h05a);
        rom[X0_READ_IDX] = encode_op(0, 5'd9, 5'd0, 5'd0, 12'h000);
        draw_bits(5, start);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            draw_bits(3, rd);
            draw_bits(4, rs1);
            draw_bits(4, rs2);
            draw_bits(12, imm);
            op   = (int'(start) + i) % 19;
            slot = (i < 20) ? (10 + i) : (BAD_IDX + 1 + i - 20);
            if ((op == 1) || (op == 3) || (op == 4) || (op == 7)) begin
                rs1 = {29'd0, rs1[1:0], 1'b1};  // Odd seeds x1..x7 are all negative
            end
            // Random writes land in x8..x15 so the seeds survive
            rom[slot] = encode_op(op, {2'b01, rd[2:0]}, rs1[4:0], rs2[4:0], imm[11:0]);
        end
        rom[BAD_IDX] = BAD_WORD;
    endtask

    assign stall_active = (phase == 0) && !is_supported(instruction) && (skip == 0);

    // ROM fetch and cycle model of the five-state control
    always @(posedge clk) begin
        pc_prev  <= pc_out;
        led_prev <= led;
        if (!rst_n) begin
            instruction  <= rom[0];
            phase        <= 0;
            skip         <= 0;
            stall_cycles <= 0;
            retired      <= 0;
            exec_idx     <= 0;
            exp_pc       <= '0;
            exp_led      <= '0;
            x0_probe     <= 1'b0;
            x0_checked   <= 1'b0;
            for (int i = 0; i < 32; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            instruction <= rom_word(int'(pc_out[31:2]) + skip);
            x0_probe    <= 1'b0;
            case (phase)
                0: begin
                    if (is_supported(instruction)) begin
                        phase      <= 1;
                        exec_idx   <= int'(pc_out[31:2]) + skip;
                        exp_rd     <= instruction[11:7];
                        exp_result <= ref_result(instruction, shadow[instruction[19:15]],
                                                 shadow[instruction[24:20]]);
                    end else if (skip == 0) begin
                        stall_cycles <= stall_cycles + 1;
                        if (stall_cycles == STALL_CYCLES - 1) begin
                            skip <= 1;  // Step the ROM past the bad word
                        end
                    end
                end
                1: phase <= 2;
                2: begin
                    phase <= 3;
                    if (exp_rd != 5'd0) begin
                        shadow[exp_rd] <= exp_result;
                    end
                    exp_led <= exp_result[7:0];
                    if (exec_idx == X0_READ_IDX) begin
                        x0_probe   <= 1'b1;
                        x0_checked <= 1'b1;
                    end
                end
                3: begin
                    phase   <= 4;
                    exp_pc  <= exp_pc + rv_pkg::PC_STEP;
                    retired <= retired + 1;
                end
                default: phase <= 0;
            endcase
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles with %0d instructions retired",
                     cycle_count, retired);
            abort_run();
        end
    end

    a_reset_pc: assert property (@(posedge clk) $rose(rst_n) |-> (pc_out == '0))
        else report_mismatch("pc_out", 32'h0, $sampled(pc_out));
    a_reset_led: assert property (@(posedge clk) $rose(rst_n) |-> (led == '0))
        else report_mismatch("led", 32'h0, {24'h0, $sampled(led)});

    a_pc_model: assert property (@(posedge clk) disable iff (!rst_n) pc_out == exp_pc)
        else report_mismatch("pc_out", $sampled(exp_pc), $sampled(pc_out));
    a_pc_step: assert property (@(posedge clk) disable iff (!rst_n)
        (pc_out != pc_prev) |-> (pc_out == pc_prev + rv_pkg::PC_STEP))
        else report_mismatch("pc_out", $sampled(pc_prev) + 32'd4, $sampled(pc_out));
    a_pc_timing: assert property (@(posedge clk) disable iff (!rst_n)
        (pc_out != pc_prev) |-> (phase == 4))
        else begin
            $display("pc_out moved %0d edges into an instruction instead of 4",
                     $sampled(phase));
            abort_run();
        end

    a_led_model: assert property (@(posedge clk) disable iff (!rst_n) led == exp_led)
        else report_mismatch("led", {24'h0, $sampled(exp_led)}, {24'h0, $sampled(led)});
    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n) x0_probe |-> (led == '0))
        else report_mismatch("led", 32'h0, {24'h0, $sampled(led)});

    a_stall_pc: assert property (@(posedge clk) disable iff (!rst_n)
        stall_active |-> (pc_out == pc_prev))
        else report_mismatch("pc_out", $sampled(pc_prev), $sampled(pc_out));
    a_stall_led: assert property (@(posedge clk) disable iff (!rst_n)
        stall_active |-> (led == led_prev))
        else report_mismatch("led", {24'h0, $sampled(led_prev)}, {24'h0, $sampled(led)});

    initial begin
        lfsr_state  = 32'hb6de7941;
        cycle_count = 0;
        rst_n       = 1'b0;
        instruction = '0;
        build_program();
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        while (retired < NUM_RETIRE) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        if (x0_checked && (stall_cycles == STALL_CYCLES)) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Program ended without reaching the x0 read and the full stall");
            abort_run();
        end
    end

endmodule : cpu_tb
